//--- Makefile
# Verilator build and run of the RV32 fetch front end.

VERILATOR ?= verilator
TOP       ?= tb_fetch
FLAGS     ?= --assert --timescale 1ns/1ps -j 0

OBJ_DIR := obj_dir
PASS    := Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f compile.f --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_fetch.sv
`include "rv_fetch_macros.svh"

module tb_fetch;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD        = 20;
    localparam int N_PROG            = 4;
    localparam int MEM_WORDS         = 16;
    localparam int MAX_RET           = 8;
    localparam int CYCLES_PER_RETIRE = 60;
    localparam logic [`RV_XLEN-1:0] BASE = `RV_RESET_PC;

    logic                clk;
    logic                rst_n;
    logic                mem_done;
    logic [`RV_XLEN-1:0] mem_rdata;
    logic                mem_req;
    logic [`RV_XLEN-1:0] mem_addr;
    logic                retire_valid;
    logic [`RV_XLEN-1:0] retire_pc;
    logic [4:0]          retire_rd;
    logic [`RV_XLEN-1:0] retire_data;

    logic [31:0] mem      [MEM_WORDS];
    logic [31:0] prog_mem [N_PROG][MEM_WORDS];
    logic [31:0] exp_pc   [N_PROG][MAX_RET];
    logic [4:0]  exp_rd   [N_PROG][MAX_RET];
    logic [31:0] exp_data [N_PROG][MAX_RET];
    logic [31:0] exp_next [N_PROG][MAX_RET]; // Fetch address after each retire.
    int          prog_ret [N_PROG];
    int          seed        = 27;
    int          errors      = 0;
    int          checks      = 0;
    logic        table_ready = 1'b0;

    fetch_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_done     (mem_done),
        .mem_rdata    (mem_rdata),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Custom-0 opcode, so stray fetches decode as no-ops.
    function automatic logic [31:0] fill_word(logic [`RV_XLEN-1:0] addr);
        return {addr[31:7] ^ addr[24:0], 7'b0001011};
    endfunction

    function automatic logic [31:0] read_word(logic [`RV_XLEN-1:0] addr);
        logic [`RV_XLEN-1:0] offset;
        offset = addr - BASE;
        if (offset < `RV_XLEN'(MEM_WORDS * 4)) begin
            return mem[offset[5:2]]; // 16 words.
        end else begin
            return fill_word(addr);
        end
    endfunction

    function automatic logic [31:0] enc_u(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, rv_fetch_pkg::OPC_LUI};
    endfunction

    function automatic logic [31:0] enc_i(rv_fetch_pkg::rv_opcode_e opc, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] funct7, logic [2:0] funct3,
                                          logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, rv_fetch_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_fetch_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] funct3, logic [4:0] rs1,
                                          logic [4:0] rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11],
                rv_fetch_pkg::OPC_BRANCH};
    endfunction

    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0d ns: %s is %h, expected %h", $time, field, got, exp);
        end
    endtask

    task automatic put_inst(input int p, input int idx, input logic [31:0] word);
        prog_mem[p][idx] = word;
    endtask

    task automatic expect_retire(input int p, input logic [31:0] pc, input logic [4:0] rd,
                                 input logic [31:0] data, input logic [31:0] next_pc);
        exp_pc[p][prog_ret[p]]   = pc;
        exp_rd[p][prog_ret[p]]   = rd;
        exp_data[p][prog_ret[p]] = data;
        exp_next[p][prog_ret[p]] = next_pc;
        prog_ret[p] = prog_ret[p] + 1;
    endtask

    task automatic load_alu_program();
        put_inst(0, 0, enc_u(5'd1, 20'h12345));
        put_inst(0, 1, enc_i(rv_fetch_pkg::OPC_OP_IMM, 5'd2, 5'd1, 12'h678));
        put_inst(0, 2, enc_i(rv_fetch_pkg::OPC_OP_IMM, 5'd3, 5'd0, 12'hFFF));
        put_inst(0, 3, enc_r(7'b0000000, 3'b000, 5'd4, 5'd2, 5'd3));
        put_inst(0, 4, enc_i(rv_fetch_pkg::OPC_OP_IMM, 5'd0, 5'd1, 12'h005));
        put_inst(0, 5, 32'h0000_050B); // Unknown opcode with rd field 10.
        put_inst(0, 6, enc_r(7'b0000000, 3'b000, 5'd5, 5'd0, 5'd4));
        expect_retire(0, BASE,         5'd1, 32'h1234_5000, BASE + 32'h04);
        expect_retire(0, BASE + 32'h04, 5'd2, 32'h1234_5678, BASE + 32'h08);
        expect_retire(0, BASE + 32'h08, 5'd3, 32'hFFFF_FFFF, BASE + 32'h0C);
        expect_retire(0, BASE + 32'h0C, 5'd4, 32'h1234_5677, BASE + 32'h10);
        expect_retire(0, BASE + 32'h10, 5'd0, 32'h0000_0000, BASE + 32'h14);
        expect_retire(0, BASE + 32'h14, 5'd0, 32'h0000_0000, BASE + 32'h18);
        expect_retire(0, BASE + 32'h18, 5'd5, 32'h1234_5677, BASE + 32'h1C);
    endtask

    task automatic load_jump_program();
        put_inst(1, 0, enc_u(5'd1, 20'h80000));
        put_inst(1, 1, enc_j(5'd2, 21'h0000C));
        put_inst(1, 4, enc_i(rv_fetch_pkg::OPC_JALR, 5'd3, 5'd1, 12'h021));
        put_inst(1, 8, enc_i(rv_fetch_pkg::OPC_OP_IMM, 5'd4, 5'd3, 12'h001));
        put_inst(1, 9, enc_i(rv_fetch_pkg::OPC_JALR, 5'd5, 5'd2, 12'h029));
        put_inst(1, 12, enc_r(7'b0000000, 3'b000, 5'd6, 5'd5, 5'd3));
        expect_retire(1, BASE,          5'd1, 32'h8000_0000, BASE + 32'h04);
        expect_retire(1, BASE + 32'h04, 5'd2, 32'h8000_0008, BASE + 32'h10);
        expect_retire(1, BASE + 32'h10, 5'd3, 32'h8000_0014, BASE + 32'h20);
        expect_retire(1, BASE + 32'h20, 5'd4, 32'h8000_0015, BASE + 32'h24);
        expect_retire(1, BASE + 32'h24, 5'd5, 32'h8000_0028, BASE + 32'h30);
        expect_retire(1, BASE + 32'h30, 5'd6, 32'h0000_003C, BASE + 32'h34);
    endtask

    task automatic load_branch_program();
        put_inst(2, 0, enc_i(rv_fetch_pkg::OPC_OP_IMM, 5'd1, 5'd0, 12'h005));
        put_inst(2, 1, enc_i(rv_fetch_pkg::OPC_OP_IMM, 5'd2, 5'd0, 12'h005));
        put_inst(2, 2, enc_b(3'b000, 5'd1, 5'd2, 13'h0008));
        put_inst(2, 4, enc_b(3'b001, 5'd1, 5'd2, 13'h000C));
        put_inst(2, 5, enc_i(rv_fetch_pkg::OPC_OP_IMM, 5'd3, 5'd0, 12'h007));
        put_inst(2, 6, enc_b(3'b000, 5'd1, 5'd3, 13'h0008));
        put_inst(2, 7, enc_b(3'b001, 5'd1, 5'd3, 13'h0008));
        put_inst(2, 9, enc_b(3'b000, 5'd0, 5'd0, 13'h1FE0)); // Back by 0x20.
        expect_retire(2, BASE,          5'd1, 32'h0000_0005, BASE + 32'h04);
        expect_retire(2, BASE + 32'h04, 5'd2, 32'h0000_0005, BASE + 32'h08);
        expect_retire(2, BASE + 32'h08, 5'd0, 32'h0000_0000, BASE + 32'h10);
        expect_retire(2, BASE + 32'h10, 5'd0, 32'h0000_0000, BASE + 32'h14);
        expect_retire(2, BASE + 32'h14, 5'd3, 32'h0000_0007, BASE + 32'h18);
        expect_retire(2, BASE + 32'h18, 5'd0, 32'h0000_0000, BASE + 32'h1C);
        expect_retire(2, BASE + 32'h1C, 5'd0, 32'h0000_0000, BASE + 32'h24);
        expect_retire(2, BASE + 32'h24, 5'd0, 32'h0000_0000, BASE + 32'h04);
    endtask

    task automatic load_muldiv_program();
        put_inst(3, 0, enc_u(5'd1, 20'h12345));
        put_inst(3, 1, enc_i(rv_fetch_pkg::OPC_OP_IMM, 5'd1, 5'd1, 12'h678));
        put_inst(3, 2, enc_i(rv_fetch_pkg::OPC_OP_IMM, 5'd2, 5'd0, 12'h3E8));
        put_inst(3, 3, enc_r(7'b0000001, 3'b000, 5'd3, 5'd1, 5'd2));
        put_inst(3, 4, enc_r(7'b0000001, 3'b101, 5'd4, 5'd3, 5'd2));
        put_inst(3, 5, enc_r(7'b0000001, 3'b101, 5'd5, 5'd1, 5'd0));
        put_inst(3, 6, enc_r(7'b0000001, 3'b000, 5'd6, 5'd5, 5'd2));
        expect_retire(3, BASE,          5'd1, 32'h1234_5000, BASE + 32'h04);
        expect_retire(3, BASE + 32'h04, 5'd1, 32'h1234_5678, BASE + 32'h08);
        expect_retire(3, BASE + 32'h08, 5'd2, 32'h0000_03E8, BASE + 32'h0C);
        expect_retire(3, BASE + 32'h0C, 5'd3, 32'h1C71_C4C0, BASE + 32'h10);
        expect_retire(3, BASE + 32'h10, 5'd4, 32'h0007_4821, BASE + 32'h14);
        expect_retire(3, BASE + 32'h14, 5'd5, 32'hFFFF_FFFF, BASE + 32'h18);
        expect_retire(3, BASE + 32'h18, 5'd6, 32'hFFFF_FC18, BASE + 32'h1C);
    endtask

    task automatic build_table();
        int p;
        int i;
        for (p = 0; p < N_PROG; p++) begin
            prog_ret[p] = 0;
            for (i = 0; i < MEM_WORDS; i++) begin
                prog_mem[p][i] = fill_word(BASE + 32'(4 * i));
            end
        end
        load_alu_program();
        load_jump_program();
        load_branch_program();
        load_muldiv_program();
    endtask

    task automatic apply_reset(input int p);
        int i;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = prog_mem[p][i];
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic run_program(input int p);
        int got;
        int reqs;
        apply_reset(p);
        got  = 0;
        reqs = 0;
        // Runs until the fetch that follows the last retire.
        while (reqs <= prog_ret[p]) begin
            @(posedge clk);
            #1;
            if (retire_valid) begin
                check_value($sformatf("p%0d fetches before retire", p), reqs, got + 1);
                if (got < prog_ret[p]) begin
                    check_value($sformatf("p%0d retire_pc[%0d]", p, got),
                                retire_pc, exp_pc[p][got]);
                    check_value($sformatf("p%0d retire_rd[%0d]", p, got),
                                {27'd0, retire_rd}, {27'd0, exp_rd[p][got]});
                    check_value($sformatf("p%0d retire_data[%0d]", p, got),
                                retire_data, exp_data[p][got]);
                end else begin
                    check_value($sformatf("p%0d retire count", p), got + 1, prog_ret[p]);
                end
                got++;
            end
            if (mem_req) begin
                check_value($sformatf("p%0d retires before fetch", p), got, reqs);
                if (reqs == 0) begin
                    check_value($sformatf("p%0d mem_addr[0]", p), mem_addr, BASE);
                end else begin
                    check_value($sformatf("p%0d mem_addr[%0d]", p, reqs),
                                mem_addr, exp_next[p][reqs - 1]);
                end
                reqs++;
            end
        end
        $display("program %0d: %0d retires, %0d fetches", p, got, reqs);
    endtask

    // Answers each request after 1 to 4 cycles.
    initial begin : memory_model
        int                  pend;
        logic [`RV_XLEN-1:0] req_addr;
        mem_done  = 1'b0;
        mem_rdata = '0;
        pend      = 0;
        req_addr  = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_done = 1'b0;
            if (!rst_n) begin
                pend = 0;
            end else begin
                if (pend > 0) begin
                    pend = pend - 1;
                    if (pend == 0) begin
                        mem_done  = 1'b1;
                        mem_rdata = read_word(req_addr);
                    end
                end
                if (mem_req) begin
                    req_addr = mem_addr;
                    pend     = 1 + ($unsigned($random(seed)) % 4);
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        int p;
        wait (table_ready);
        limit = 50;
        for (p = 0; p < N_PROG; p++) begin
            limit = limit + (prog_ret[p] + 1) * CYCLES_PER_RETIRE + 4;
        end
        #(limit * CLK_PERIOD);
        $display("timeout: retire count not reached");
        $display("%0d errors in %0d checks", errors, checks);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main_sequence
        int p;
        rst_n = 1'b0;
        build_table();
        table_ready = 1'b1;
        for (p = 0; p < N_PROG; p++) begin
            run_program(p);
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/rv_fetch_pkg.sv
design/pc_gen.sv
design/fetch_unit.sv
design/decode_exec.sv
design/muldiv_seq.sv
design/fetch_top.sv
bench/tb_fetch.sv

//--- design/decode_exec.sv
`include "rv_fetch_macros.svh"

module decode_exec (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inst_valid,
    input  logic [`RV_XLEN-1:0]     inst,
    input  logic [`RV_XLEN-1:0]     inst_pc,
    input  logic                    md_done,
    input  logic [`RV_XLEN-1:0]     md_result,
    output logic                    md_start,
    output rv_fetch_pkg::op_class_e md_class,
    output logic [`RV_XLEN-1:0]     md_a,
    output logic [`RV_XLEN-1:0]     md_b,
    output logic                    pc_step,
    output logic                    pc_redirect,
    output logic [`RV_XLEN-1:0]     redirect_pc,
    output logic                    retire_valid,
    output logic [`RV_XLEN-1:0]     retire_pc,
    output logic [4:0]              retire_rd,
    output logic [`RV_XLEN-1:0]     retire_data
);

    rv_fetch_pkg::exec_state_e state_q;
    rv_fetch_pkg::rv_opcode_e  opcode;
    rv_fetch_pkg::op_class_e   cls;
    logic [`RV_XLEN-1:0] regs [1:31];
    logic [4:0]          rd, rs1, rs2;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i, imm_j, imm_b, imm_u;
    logic [`RV_XLEN-1:0] rs1_val, rs2_val, alu_res, link;
    logic                take;
    logic [`RV_XLEN-1:0] pc_q, link_q, jalr_tgt_q;
    logic [4:0]          rd_q;
    logic                ret_now, step_n, redir_n;
    logic [`RV_XLEN-1:0] redir_pc_n, ret_pc_n, ret_res_n;
    logic [4:0]          ret_rd_n;

    assign opcode = rv_fetch_pkg::rv_opcode_e'(inst[6:0]);
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 reads as zero.
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign link    = inst_pc + `RV_XLEN'(4);

    always_comb begin
        cls = rv_fetch_pkg::CLS_NOP; // Unknown encodings retire as no-ops.
        case (opcode)
            rv_fetch_pkg::OPC_LUI: cls = rv_fetch_pkg::CLS_ALU;
            rv_fetch_pkg::OPC_OP_IMM: if (funct3 == 3'b000) cls = rv_fetch_pkg::CLS_ALU;
            rv_fetch_pkg::OPC_OP: begin
                if (funct7 == 7'b0000000 && funct3 == 3'b000) cls = rv_fetch_pkg::CLS_ALU;
                if (funct7 == 7'b0000001 && funct3 == 3'b000) cls = rv_fetch_pkg::CLS_MUL;
                if (funct7 == 7'b0000001 && funct3 == 3'b101) cls = rv_fetch_pkg::CLS_DIV;
            end
            rv_fetch_pkg::OPC_JAL: cls = rv_fetch_pkg::CLS_JAL;
            rv_fetch_pkg::OPC_JALR: if (funct3 == 3'b000) cls = rv_fetch_pkg::CLS_JALR;
            rv_fetch_pkg::OPC_BRANCH: if (funct3[2:1] == 2'b00) cls = rv_fetch_pkg::CLS_BRANCH;
            default: cls = rv_fetch_pkg::CLS_NOP;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_fetch_pkg::OPC_LUI:    alu_res = imm_u;
            rv_fetch_pkg::OPC_OP_IMM: alu_res = rs1_val + imm_i;
            default:                  alu_res = rs1_val + rs2_val;
        endcase
    end

    // BEQ on funct3 000, BNE on 001.
    assign take = (rs1_val == rs2_val) ^ funct3[0];

    always_comb begin
        ret_now    = 1'b0;
        step_n     = 1'b0;
        redir_n    = 1'b0;
        redir_pc_n = jalr_tgt_q;
        ret_rd_n   = 5'd0;
        ret_res_n  = '0;
        ret_pc_n   = pc_q;
        case (state_q)
            rv_fetch_pkg::ES_IDLE: begin
                ret_pc_n = inst_pc;
                if (inst_valid) begin
                    case (cls)
                        rv_fetch_pkg::CLS_ALU: begin
                            ret_now   = 1'b1;
                            step_n    = 1'b1;
                            ret_rd_n  = rd;
                            ret_res_n = alu_res;
                        end
                        rv_fetch_pkg::CLS_JAL: begin
                            ret_now    = 1'b1;
                            redir_n    = 1'b1;
                            redir_pc_n = inst_pc + imm_j;
                            ret_rd_n   = rd;
                            ret_res_n  = link;
                        end
                        rv_fetch_pkg::CLS_BRANCH: begin
                            ret_now    = 1'b1;
                            redir_n    = take;
                            step_n     = !take;
                            redir_pc_n = inst_pc + imm_b;
                        end
                        rv_fetch_pkg::CLS_NOP: begin
                            ret_now = 1'b1;
                            step_n  = 1'b1;
                        end
                        default: ret_now = 1'b0; // JALR and mul/div retire later.
                    endcase
                end
            end
            rv_fetch_pkg::ES_JALR_WAIT: begin
                ret_now   = 1'b1;
                redir_n   = 1'b1;
                ret_rd_n  = rd_q;
                ret_res_n = link_q;
            end
            rv_fetch_pkg::ES_MD_WAIT: begin
                ret_now   = md_done;
                step_n    = md_done;
                ret_rd_n  = rd_q;
                ret_res_n = md_result;
            end
            default: ret_now = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= rv_fetch_pkg::ES_IDLE;
            retire_valid <= 1'b0;
            pc_step      <= 1'b0;
            pc_redirect  <= 1'b0;
            md_start     <= 1'b0;
        end else begin
            retire_valid <= ret_now;
            pc_step      <= step_n;
            pc_redirect  <= redir_n;
            md_start     <= 1'b0;
            case (state_q)
                rv_fetch_pkg::ES_IDLE: begin
                    if (inst_valid && cls == rv_fetch_pkg::CLS_JALR) begin
                        state_q <= rv_fetch_pkg::ES_JALR_WAIT;
                    end
                    if (inst_valid && (cls == rv_fetch_pkg::CLS_MUL ||
                                       cls == rv_fetch_pkg::CLS_DIV)) begin
                        md_start <= 1'b1;
                        state_q  <= rv_fetch_pkg::ES_MD_WAIT;
                    end
                end
                rv_fetch_pkg::ES_JALR_WAIT: state_q <= rv_fetch_pkg::ES_IDLE;
                rv_fetch_pkg::ES_MD_WAIT: if (md_done) state_q <= rv_fetch_pkg::ES_IDLE;
                default: state_q <= rv_fetch_pkg::ES_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == rv_fetch_pkg::ES_IDLE && inst_valid) begin
            pc_q       <= inst_pc;
            rd_q       <= rd;
            link_q     <= link;
            jalr_tgt_q <= (rs1_val + imm_i) & ~`RV_XLEN'(1); // Bit 0 cleared.
            md_class   <= cls;
            md_a       <= rs1_val;
            md_b       <= rs2_val;
        end
        redirect_pc <= redir_pc_n;
        retire_pc   <= ret_pc_n;
        retire_rd   <= ret_rd_n;
        retire_data <= (ret_rd_n == 5'd0) ? '0 : ret_res_n;
        if (ret_now && ret_rd_n != 5'd0) begin
            regs[ret_rd_n] <= ret_res_n;
        end
    end

    a_valid_in_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        inst_valid |-> state_q == rv_fetch_pkg::ES_IDLE
    ) else $error("decode_exec: instruction arrived while busy");

endmodule

//--- design/fetch_top.sv
`include "rv_fetch_macros.svh"

module fetch_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_done,
    input  logic [`RV_XLEN-1:0] mem_rdata,
    output logic                mem_req,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data
);

    logic                    fetch_start;
    logic [`RV_XLEN-1:0]     fetch_pc;
    logic                    inst_valid;
    logic [`RV_XLEN-1:0]     inst;
    logic [`RV_XLEN-1:0]     inst_pc;
    logic                    pc_step;
    logic                    pc_redirect;
    logic [`RV_XLEN-1:0]     redirect_pc;
    logic                    md_start;
    rv_fetch_pkg::op_class_e md_class;
    logic [`RV_XLEN-1:0]     md_a;
    logic [`RV_XLEN-1:0]     md_b;
    logic                    md_done;
    logic [`RV_XLEN-1:0]     md_result;

    pc_gen u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_step     (pc_step),
        .pc_redirect (pc_redirect),
        .redirect_pc (redirect_pc),
        .fetch_start (fetch_start),
        .fetch_pc    (fetch_pc)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .fetch_pc    (fetch_pc),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc)
    );

    decode_exec u_decode_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .md_done      (md_done),
        .md_result    (md_result),
        .md_start     (md_start),
        .md_class     (md_class),
        .md_a         (md_a),
        .md_b         (md_b),
        .pc_step      (pc_step),
        .pc_redirect  (pc_redirect),
        .redirect_pc  (redirect_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    muldiv_seq u_muldiv_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .md_start  (md_start),
        .md_class  (md_class),
        .md_a      (md_a),
        .md_b      (md_b),
        .md_done   (md_done),
        .md_result (md_result)
    );

endmodule

//--- design/fetch_unit.sv
`include "rv_fetch_macros.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_start,
    input  logic [`RV_XLEN-1:0] fetch_pc,
    input  logic                mem_done,
    input  logic [`RV_XLEN-1:0] mem_rdata,
    output logic                mem_req,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic                inst_valid,
    output logic [`RV_XLEN-1:0] inst,
    output logic [`RV_XLEN-1:0] inst_pc
);

    rv_fetch_pkg::fetch_state_e state_q;
    logic [`RV_XLEN-1:0]        addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= rv_fetch_pkg::FS_IDLE;
            mem_req    <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            mem_req    <= 1'b0;
            inst_valid <= 1'b0;
            case (state_q)
                rv_fetch_pkg::FS_IDLE: begin
                    if (fetch_start) begin
                        mem_req <= 1'b1;
                        state_q <= rv_fetch_pkg::FS_WAIT_MEM;
                    end
                end
                rv_fetch_pkg::FS_WAIT_MEM: begin
                    if (mem_done) begin
                        inst_valid <= 1'b1;
                        state_q    <= rv_fetch_pkg::FS_IDLE;
                    end
                end
                default: state_q <= rv_fetch_pkg::FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start && state_q == rv_fetch_pkg::FS_IDLE) begin
            addr_q <= fetch_pc;
        end
        if (mem_done && state_q == rv_fetch_pkg::FS_WAIT_MEM) begin
            inst    <= mem_rdata;
            inst_pc <= addr_q;
        end
    end

    assign mem_addr = addr_q;

    a_no_done_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_done |-> state_q == rv_fetch_pkg::FS_WAIT_MEM
    ) else $error("fetch_unit: mem_done without a request");

    a_no_start_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_start |-> state_q == rv_fetch_pkg::FS_IDLE
    ) else $error("fetch_unit: fetch_start while waiting");

endmodule

//--- design/muldiv_seq.sv
`include "rv_fetch_macros.svh"

module muldiv_seq (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    md_start,
    input  rv_fetch_pkg::op_class_e md_class,
    input  logic [`RV_XLEN-1:0]     md_a,
    input  logic [`RV_XLEN-1:0]     md_b,
    output logic                    md_done,
    output logic [`RV_XLEN-1:0]     md_result
);

    localparam int CNT_W = $clog2(`RV_MD_STEPS);

    rv_fetch_pkg::md_state_e state_q;
    logic [CNT_W-1:0]        cnt_q;
    logic                    is_mul_q;
    logic [`RV_XLEN-1:0]     hi_q;   // Product or partial remainder.
    logic [`RV_XLEN-1:0]     lo_q;   // Multiplier or quotient.
    logic [`RV_XLEN-1:0]     opnd_q; // Multiplicand or divisor.
    logic [`RV_XLEN:0]       rem_sh;
    logic [`RV_XLEN:0]       trial;

    assign rem_sh = {hi_q, lo_q[`RV_XLEN-1]};
    assign trial  = rem_sh - {1'b0, opnd_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= rv_fetch_pkg::MD_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                rv_fetch_pkg::MD_IDLE: begin
                    cnt_q <= '0;
                    if (md_start) state_q <= rv_fetch_pkg::MD_BUSY;
                end
                rv_fetch_pkg::MD_BUSY: begin
                    cnt_q <= cnt_q + CNT_W'(1);
                    if (cnt_q == CNT_W'(`RV_MD_STEPS - 1)) state_q <= rv_fetch_pkg::MD_FINISH;
                end
                default: state_q <= rv_fetch_pkg::MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == rv_fetch_pkg::MD_IDLE && md_start) begin
            is_mul_q <= (md_class == rv_fetch_pkg::CLS_MUL);
            hi_q     <= '0;
            lo_q     <= (md_class == rv_fetch_pkg::CLS_MUL) ? md_b : md_a;
            opnd_q   <= (md_class == rv_fetch_pkg::CLS_MUL) ? md_a : md_b;
        end else if (state_q == rv_fetch_pkg::MD_BUSY) begin
            if (is_mul_q) begin
                if (lo_q[0]) hi_q <= hi_q + opnd_q;
                opnd_q <= opnd_q << 1;
                lo_q   <= lo_q >> 1;
            end else if (!trial[`RV_XLEN]) begin
                // Zero divisor always subtracts, so the quotient ends all ones.
                hi_q <= trial[`RV_XLEN-1:0];
                lo_q <= {lo_q[`RV_XLEN-2:0], 1'b1};
            end else begin
                hi_q <= rem_sh[`RV_XLEN-1:0];
                lo_q <= {lo_q[`RV_XLEN-2:0], 1'b0};
            end
        end
    end

    assign md_done   = (state_q == rv_fetch_pkg::MD_FINISH);
    assign md_result = is_mul_q ? hi_q : lo_q;

    a_no_start_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        md_start |-> state_q == rv_fetch_pkg::MD_IDLE
    ) else $error("muldiv_seq: start while busy");

endmodule

//--- design/pc_gen.sv
`include "rv_fetch_macros.svh"

module pc_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pc_step,
    input  logic                pc_redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    output logic                fetch_start,
    output logic [`RV_XLEN-1:0] fetch_pc
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_next;
    logic                boot_q;

    always_comb begin
        if (pc_redirect) begin
            pc_next = redirect_pc;
        end else if (pc_step) begin
            pc_next = pc_q + `RV_XLEN'(4);
        end else begin
            pc_next = pc_q; // Hold while an instruction is in flight.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Boot flag stays up for the first cycle out of reset only.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boot_q <= 1'b1;
        end else begin
            boot_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_start <= 1'b0;
        end else begin
            fetch_start <= boot_q | pc_step | pc_redirect; // New PC visible with it.
        end
    end

    assign fetch_pc = pc_q;

    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00
    ) else $error("pc_gen: PC not word aligned");

    a_step_redirect_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(pc_step && pc_redirect)
    ) else $error("pc_gen: step and redirect together");

endmodule

//--- design/rv_fetch_macros.svh
`ifndef RV_FETCH_MACROS_SVH
`define RV_FETCH_MACROS_SVH

// Data and address width.
`define RV_XLEN 32

// First fetch address after reset.
`define RV_RESET_PC 32'h8000_0000

// Shift-add and restoring divide iterations.
`define RV_MD_STEPS 32

`endif

//--- design/rv_fetch_pkg.sv
package rv_fetch_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_MUL,
        CLS_DIV,
        CLS_NOP
    } op_class_e;

    typedef enum logic {
        FS_IDLE,
        FS_WAIT_MEM
    } fetch_state_e;

    typedef enum logic [1:0] {
        ES_IDLE,
        ES_JALR_WAIT,
        ES_MD_WAIT
    } exec_state_e;

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_BUSY,
        MD_FINISH
    } md_state_e;

endpackage
